//--- verilog/cache_pkg.sv
package cache_pkg;

  // cpu side view of the address
  // a word address splits as | tag 29:9 | index 8:4 | offset 3:0 |

  // word address, byte offset already stripped by the cpu
  typedef logic [29:0] word_addr_t;

  // tag field, compared against both ways
  typedef logic [20:0] tag_t;

  // set index
  typedef logic [4:0] index_t;

  // word within a 16 word line
  // upper two bits pick the beat, lower two the word inside it
  typedef logic [3:0] offset_t;

  // one instruction word
  typedef logic [31:0] word_t;

  // two ways, so one bit
  typedef logic [0:0] way_t;

  // 32 sets, matches the index width
  localparam int NUM_SETS = 32;

endpackage

//--- verilog/mem_pkg.sv
package mem_pkg;

  import cache_pkg::*;

  // line address sent to memory, tag then index
  typedef logic [$bits(tag_t)+$bits(index_t)-1:0] line_addr_t;

  // one response beat, four words, lowest address in the low bits
  typedef logic [127:0] beat_t;

  // beat number inside a line
  typedef logic [1:0] beat_cnt_t;

  localparam int BEATS_PER_LINE = 4;

  // miss sequencing, only refill_ctrl steps through these
  typedef enum logic [1:0] {
    st_idle,
    st_request,  // line read offered to memory
    st_refill    // collecting beats
  } refill_state_t;

endpackage

//--- verilog/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  logic       i_req_valid,
  input  word_addr_t i_req_addr,
  output logic       o_req_ready,

  input  logic       i_busy,       // refill in progress
  input  logic       i_fill_done,  // last beat of the line this cycle
  input  way_t       i_fill_way,

  output logic       o_hit,
  output way_t       o_hit_way,
  output logic       o_miss,
  output way_t       o_victim_way,
  output tag_t       o_req_tag,
  output index_t     o_req_index,
  output offset_t    o_req_offset
);

  // lookup stage
  logic       stage_valid;
  line_addr_t req_line;    // tag and index of the held request
  offset_t    req_offset;
  logic       accept;

  // per way tag and valid arrays
  tag_t tag_mem   [0:1][0:NUM_SETS-1];
  logic valid_mem [0:1][0:NUM_SETS-1];

  // replacement state, 1 means way 0 goes next
  logic victim_mem [0:NUM_SETS-1];

  logic [1:0] way_hit;

  assign accept = i_req_valid && o_req_ready;

  assign {o_req_tag, o_req_index} = req_line;
  assign o_req_offset = req_offset;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else if (accept) begin
      stage_valid <= 1'b1;
    end else if (o_hit) begin
      stage_valid <= 1'b0;  // response went out, stage empties
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_line   <= i_req_addr[29:4];
      req_offset <= i_req_addr[3:0];
    end
  end

  // compare held tag against both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = stage_valid && valid_mem[w][o_req_index] &&
                   (tag_mem[w][o_req_index] == o_req_tag);
    end
  end

  assign o_hit        = |way_hit;
  assign o_hit_way    = way_t'(way_hit[1]);
  assign o_miss       = stage_valid && !o_hit;
  assign o_victim_way = way_t'(!victim_mem[o_req_index]);

  // a held miss blocks new requests until the refilled line hits
  assign o_req_ready = !o_miss && !i_busy;

  // the bit always ends up pointing away from the way just used,
  // whether that was a hit or a fill
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[0][s] <= 1'b0;
        valid_mem[1][s] <= 1'b0;
        victim_mem[s]   <= 1'b0;
      end
    end else if (i_fill_done) begin
      valid_mem[i_fill_way][o_req_index] <= 1'b1;
      victim_mem[o_req_index]            <= i_fill_way;
    end else if (o_hit) begin
      victim_mem[o_req_index] <= o_hit_way;
    end
  end

  // tag installed with the last beat, the held request hits next cycle
  always_ff @(posedge clk) begin
    if (i_fill_done) begin
      tag_mem[i_fill_way][o_req_index] <= o_req_tag;
    end
  end

endmodule

//--- verilog/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // from the lookup stage
  input  logic       i_miss,
  input  way_t       i_victim_way,
  input  tag_t       i_req_tag,
  input  index_t     i_req_index,
  output logic       o_busy,

  // memory request
  output logic       o_mem_req_valid,
  input  logic       i_mem_req_ready,
  output line_addr_t o_mem_req_addr,

  // memory response
  input  logic       i_mem_resp_valid,
  input  beat_t      i_mem_resp_data,

  // fill writes toward the data arrays
  output logic       o_fill_valid,
  output way_t       o_fill_way,
  output beat_cnt_t  o_fill_beat_num,
  output beat_t      o_fill_data,
  output logic       o_fill_done
);

  refill_state_t state, state_nxt;
  beat_cnt_t     beat_cnt;
  way_t          fill_way;   // victim picked when the miss was seen
  logic          last_beat;

  assign last_beat = (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (i_miss) begin
          state_nxt = st_request;
        end
      end
      st_request: begin
        if (i_mem_req_ready) begin
          state_nxt = st_refill;  // handshake done
        end
      end
      st_refill: begin
        if (o_fill_done) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      // wraps back to 0 after the fourth beat
      if (o_fill_valid) begin
        beat_cnt <= beat_cnt + beat_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && i_miss) begin
      fill_way <= i_victim_way;
    end
  end

  assign o_busy = (state != st_idle);

  // request held in the lookup stage for the whole miss
  assign o_mem_req_valid = (state == st_request);
  assign o_mem_req_addr  = {i_req_tag, i_req_index};

  // each beat goes straight through to the data arrays
  assign o_fill_valid    = (state == st_refill) && i_mem_resp_valid;
  assign o_fill_way      = fill_way;
  assign o_fill_beat_num = beat_cnt;
  assign o_fill_data     = i_mem_resp_data;
  assign o_fill_done     = o_fill_valid && last_beat;

endmodule

//--- verilog/line_store.sv
`timescale 1ns/1ps

module line_store
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk,

  // fill side, one beat per write
  input  logic      i_fill_valid,
  input  way_t      i_fill_way,
  input  beat_cnt_t i_fill_beat_num,
  input  beat_t     i_fill_data,

  // read side, driven by the lookup stage
  input  index_t    i_req_index,   // also the fill index
  input  offset_t   i_req_offset,
  input  way_t      i_hit_way,

  output word_t     o_resp_data
);

  // way x set x beat
  beat_t data_mem [0:1][0:NUM_SETS-1][0:BEATS_PER_LINE-1];

  beat_t     rd_beat;
  beat_cnt_t rd_beat_num;
  logic [1:0] word_sel;

  always_ff @(posedge clk) begin
    if (i_fill_valid) begin
      data_mem[i_fill_way][i_req_index][i_fill_beat_num] <= i_fill_data;
    end
  end

  // upper offset bits pick the beat
  assign rd_beat_num = i_req_offset[3:2];
  assign word_sel    = i_req_offset[1:0];

  assign rd_beat = data_mem[i_hit_way][i_req_index][rd_beat_num];

  // then the word, word 0 sits in the low bits
  assign o_resp_data = rd_beat[word_sel*$bits(word_t) +: $bits(word_t)];

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // cpu request
  input  logic       i_req_valid,
  input  word_addr_t i_req_addr,
  output logic       o_req_ready,

  // cpu response, no back-pressure
  output logic       o_resp_valid,
  output word_t      o_resp_data,

  // memory request
  output logic       o_mem_req_valid,
  input  logic       i_mem_req_ready,
  output line_addr_t o_mem_req_addr,

  // memory response, four beats per line
  input  logic       i_mem_resp_valid,
  input  beat_t      i_mem_resp_data
);

  logic      miss;
  way_t      victim_way;
  way_t      hit_way;
  tag_t      req_tag;
  index_t    req_index;
  offset_t   req_offset;
  logic      busy;

  logic      fill_valid;
  way_t      fill_way;
  beat_cnt_t fill_beat_num;
  beat_t     fill_data;
  logic      fill_done;

  tag_lookup u_tag_lookup (
    .clk          (clk),
    .reset        (reset),
    .i_req_valid  (i_req_valid),
    .i_req_addr   (i_req_addr),
    .o_req_ready  (o_req_ready),
    .i_busy       (busy),
    .i_fill_done  (fill_done),
    .i_fill_way   (fill_way),
    .o_hit        (o_resp_valid),  // a hit is the response
    .o_hit_way    (hit_way),
    .o_miss       (miss),
    .o_victim_way (victim_way),
    .o_req_tag    (req_tag),
    .o_req_index  (req_index),
    .o_req_offset (req_offset)
  );

  refill_ctrl u_refill_ctrl (
    .clk              (clk),
    .reset            (reset),
    .i_miss           (miss),
    .i_victim_way     (victim_way),
    .i_req_tag        (req_tag),
    .i_req_index      (req_index),
    .o_busy           (busy),
    .o_mem_req_valid  (o_mem_req_valid),
    .i_mem_req_ready  (i_mem_req_ready),
    .o_mem_req_addr   (o_mem_req_addr),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data),
    .o_fill_valid     (fill_valid),
    .o_fill_way       (fill_way),
    .o_fill_beat_num  (fill_beat_num),
    .o_fill_data      (fill_data),
    .o_fill_done      (fill_done)
  );

  line_store u_line_store (
    .clk             (clk),
    .i_fill_valid    (fill_valid),
    .i_fill_way      (fill_way),
    .i_fill_beat_num (fill_beat_num),
    .i_fill_data     (fill_data),
    .i_req_index     (req_index),
    .i_req_offset    (req_offset),
    .i_hit_way       (hit_way),
    .o_resp_data     (o_resp_data)
  );

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import cache_pkg::*;
  import mem_pkg::*;
();

  localparam int CYCLES_PER_ENTRY = 40;

  localparam tag_t TAG_A = 21'h12345;
  localparam tag_t TAG_B = 21'h1f0f0;
  localparam tag_t TAG_C = 21'h0a5c3;

  typedef struct packed {
    word_addr_t addr;
    logic       miss;  // expected to fetch from memory
    way_t       way;   // way holding the line afterwards
    logic       b2b;   // driven in the cycle right after the previous acceptance
  } entry_t;

  logic       clk;
  logic       reset;
  logic       i_req_valid;
  word_addr_t i_req_addr;
  logic       o_req_ready;
  logic       o_resp_valid;
  word_t      o_resp_data;
  logic       o_mem_req_valid;
  logic       i_mem_req_ready;
  line_addr_t o_mem_req_addr;
  logic       i_mem_resp_valid;
  beat_t      i_mem_resp_data;

  entry_t     tbl [$];
  int         tbl_len = 0;
  int         value_errs = 0;
  int         flow_errs = 0;
  int         mem_req_count = 0;  // completed memory request handshakes
  line_addr_t last_req_line;

  // reference copy of the tag side
  logic m_valid  [0:1][0:NUM_SETS-1];
  tag_t m_tag    [0:1][0:NUM_SETS-1];
  logic m_victim [0:NUM_SETS-1];

  icache_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .i_req_valid      (i_req_valid),
    .i_req_addr       (i_req_addr),
    .o_req_ready      (o_req_ready),
    .o_resp_valid     (o_resp_valid),
    .o_resp_data      (o_resp_data),
    .o_mem_req_valid  (o_mem_req_valid),
    .i_mem_req_ready  (i_mem_req_ready),
    .o_mem_req_addr   (o_mem_req_addr),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // memory content is the word address xor a fixed mask
  function automatic word_t pattern_word(word_addr_t a);
    return {2'b00, a} ^ 32'h5a5a_0000;
  endfunction

  function automatic beat_t beat_for(line_addr_t line, beat_cnt_t num);
    beat_t data;
    for (int w = 0; w < 4; w++) begin
      data[w*32 +: 32] = pattern_word({line, num, 2'(w)});  // lowest word in low bits
    end
    return data;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic check_line_addr(input string name, input line_addr_t got,
                                 input line_addr_t exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic check_way(input string name, input way_t got, input way_t exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  // victim bit 1 names way 0 and the bit follows the way last used
  task automatic predict(input word_addr_t a, output logic miss, output way_t way);
    tag_t   t;
    index_t s;
    t    = a[29:9];
    s    = a[8:4];
    miss = 1'b1;
    way  = way_t'(!m_victim[s]);
    for (int w = 0; w < 2; w++) begin
      if (m_valid[w][s] && m_tag[w][s] == t) begin
        miss = 1'b0;
        way  = way_t'(w);
      end
    end
    if (miss) begin
      m_valid[way][s] = 1'b1;
      m_tag[way][s]   = t;
    end
    m_victim[s] = way;
  endtask

  task automatic add_entry(input tag_t t, input int set, input int off, input int miss,
                           input int way, input int b2b);
    entry_t e;
    e.addr = {t, index_t'(set), offset_t'(off)};
    e.miss = (miss != 0);
    e.way  = way_t'(way);
    e.b2b  = (b2b != 0);
    tbl.push_back(e);
  endtask

  task automatic build_table();
    add_entry(TAG_A, 3, 5, 1, 1, 0);  // cold set so victim bit 0 picks way 1
    for (int o = 0; o < 16; o++) begin
      if (o != 5) begin
        add_entry(TAG_A, 3, o, 0, 1, 1);  // rest of the line one per cycle
      end
    end
    add_entry(TAG_B, 3, 9, 1, 0, 0);
    for (int k = 0; k < 2; k++) begin
      add_entry(TAG_A, 3, 1, 0, 1, 1);
      add_entry(TAG_B, 3, 14, 0, 0, 1);
    end
    // last hit was way 0 so tag C throws out tag A
    add_entry(TAG_C, 3, 7, 1, 1, 0);
    add_entry(TAG_B, 3, 3, 0, 0, 0);
    add_entry(TAG_A, 3, 5, 1, 1, 0);
    add_entry(TAG_B, 3, 0, 0, 0, 1);
    add_entry(TAG_C, 3, 12, 1, 1, 0);
    add_entry(TAG_B, 3, 15, 0, 0, 1);
    add_entry(TAG_C, 3, 12, 0, 1, 1);
    add_entry(TAG_A, 3, 2, 1, 0, 0);  // way 0 is the victim this time
    add_entry(TAG_B, 3, 6, 1, 1, 0);
    add_entry(TAG_A, 3, 2, 0, 0, 1);
    add_entry(TAG_A, 0, 0, 1, 1, 0);
    add_entry(TAG_A, 0, 15, 0, 1, 1);
    add_entry(TAG_C, 31, 8, 1, 1, 0);
    add_entry(TAG_B, 31, 8, 1, 0, 1);  // waits behind the refill in front of it
    add_entry(TAG_C, 31, 11, 0, 1, 1);
    add_entry(TAG_B, 17, 4, 1, 1, 0);
    add_entry(TAG_B, 17, 10, 0, 1, 1);
  endtask

  // memory with random ready delay and beat gaps
  initial begin : mem_model
    int         gap;
    line_addr_t line;
    void'($urandom(32'h8e24));
    i_mem_req_ready  = 1'b0;
    i_mem_resp_valid = 1'b0;
    i_mem_resp_data  = '0;
    forever begin
      next_cycle();
      if (!reset && o_mem_req_valid === 1'b1) begin
        line = o_mem_req_addr;
        gap  = $urandom_range(0, 3);
        repeat (gap) next_cycle();
        i_mem_req_ready = 1'b1;
        next_cycle();  // handshake on this edge
        i_mem_req_ready = 1'b0;
        last_req_line   = line;
        mem_req_count++;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
          gap = $urandom_range(0, 2);
          repeat (gap) next_cycle();
          i_mem_resp_valid = 1'b1;
          i_mem_resp_data  = beat_for(line, beat_cnt_t'(b));
          next_cycle();
          i_mem_resp_valid = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    wait (tbl_len > 0);
    repeat (tbl_len * CYCLES_PER_ENTRY + 10) @(posedge clk);
    $display("timeout: table not finished after %0d cycles", tbl_len * CYCLES_PER_ENTRY + 10);
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    logic   pred_miss;
    way_t   pred_way;
    int     mem_before;
    int     lat;
    int     ready_high;
    logic   next_b2b;
    entry_t e;

    reset       = 1'b1;
    i_req_valid = 1'b0;
    i_req_addr  = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_tag[0][s]   = '0;
      m_tag[1][s]   = '0;
      m_victim[s]   = 1'b0;
    end
    build_table();
    tbl_len = tbl.size();

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    if (o_req_ready !== 1'b1) begin
      $display("o_req_ready is not high after reset");
      flow_errs++;
    end
    if (o_mem_req_valid !== 1'b0 || o_resp_valid !== 1'b0) begin
      $display("memory request or response is active right after reset");
      flow_errs++;
    end

    i_req_valid = 1'b1;
    i_req_addr  = tbl[0].addr;
    for (int i = 0; i < tbl_len; i++) begin
      e        = tbl[i];
      next_b2b = (i + 1 < tbl_len) && tbl[i + 1].b2b;
      predict(e.addr, pred_miss, pred_way);
      if (pred_miss !== e.miss || pred_way !== e.way) begin
        $display("entry %0d: table says miss %0d way %0d, the model says miss %0d way %0d",
                 i, e.miss, e.way, pred_miss, pred_way);
        flow_errs++;
      end
      while (o_req_ready !== 1'b1) next_cycle();
      mem_before = mem_req_count;
      next_cycle();  // accepted on this edge
      if (next_b2b) begin
        i_req_addr = tbl[i + 1].addr;
      end else begin
        i_req_valid = 1'b0;
      end
      lat        = 0;
      ready_high = 0;
      while (o_resp_valid !== 1'b1) begin
        if (o_req_ready !== 1'b0) ready_high++;
        next_cycle();
        lat++;
      end
      if (pred_miss) begin
        if (mem_req_count - mem_before != 1) begin
          $display("entry %0d: expected a miss with one memory request, saw %0d requests",
                   i, mem_req_count - mem_before);
          flow_errs++;
        end
        check_line_addr("o_mem_req_addr", last_req_line, e.addr[29:4]);
        if (ready_high != 0) begin
          $display("entry %0d: o_req_ready was high for %0d cycles of the miss", i, ready_high);
          flow_errs++;
        end
      end else begin
        if (mem_req_count != mem_before) begin
          $display("entry %0d: expected a hit but the cache fetched from memory", i);
          flow_errs++;
        end
        if (lat != 0) begin
          $display("entry %0d: hit response came %0d cycles late", i, lat);
          flow_errs++;
        end
      end
      check_word("o_resp_data", o_resp_data, pattern_word(e.addr));
      check_way("hit_way", i_dut.hit_way, pred_way);
      if (!next_b2b) begin
        next_cycle();
        if (i + 1 < tbl_len) begin
          i_req_valid = 1'b1;
          i_req_addr  = tbl[i + 1].addr;
        end
      end
    end

    next_cycle();
    if (o_mem_req_valid !== 1'b0 || o_resp_valid !== 1'b0) begin
      $display("cache still active after the last response");
      flow_errs++;
    end

    $display("errors: %0d value, %0d protocol", value_errs, flow_errs);
    if (value_errs + flow_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/tag_lookup.sv
verilog/refill_ctrl.sv
verilog/line_store.sv
verilog/icache_top.sv
verif/icache_tb.sv

//--- Makefile
# Verilator build and run for the instruction cache

VERILATOR ?= verilator
TOP       ?= icache_tb
RTL_TOP   ?= icache_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

RTL_SRCS  := $(filter verilog/%.sv,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
